// ==== eth_tx_noc.f ====
+incdir+hw
hw/noc_msg_pkg.sv
hw/eth_frame_pkg.sv
hw/eth_tx_noc_in_ctrl.sv
hw/eth_tx_noc_in_datap.sv
hw/eth_tx_frame_fmt.sv
hw/eth_tx_noc_in.sv
test/eth_tx_noc_in_tb.sv

// ==== Makefile ====
# Verilator build and run of the eth_tx_noc testbench.

TOP       ?= eth_tx_noc_in_tb
FILELIST  ?= eth_tx_noc.f
OBJ_DIR   ?= ./obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All checks passed

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard hw/*.sv hw/*.svh test/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: TOP FILELIST OBJ_DIR VERILATOR VFLAGS PASS_MSG"

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== test/eth_tx_noc_in_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "eth_tx_consts.svh"

module eth_tx_noc_in_tb;

    import noc_msg_pkg::*;
    import eth_frame_pkg::*;

    localparam int NUM_ROWS = 8;
    localparam logic [7:0] GAP_RAND = 8'hff;   // Gap drawn at random from 1 to 4 cycles.

    typedef struct packed {
        logic [`MSG_LENGTH_WIDTH-1:0]   msg_len;
        logic [`ETH_ADDR_W-1:0]         eth_dst;
        logic [`ETH_ADDR_W-1:0]         eth_src;
        logic [`ETH_TYPE_W-1:0]         eth_type;
        logic [`MTU_SIZE_W-1:0]         payload_size;
        logic [MSG_TIMESTAMP_W-1:0]     timestamp;
        logic [7:0]                     gap;
    } msg_row_t;

    typedef struct {
        mac_beat_e                      kind;
        logic [`MAC_INTERFACE_W-1:0]    data;
        logic                           last;
        logic [`MAC_PADBYTES_W-1:0]     pad;
        int                             due;   // Cycle at which the beat must show.
        int                             row;
    } exp_beat_t;

    // msg_len, eth_dst, eth_src, eth_type, payload_size, timestamp, gap
    msg_row_t rows [NUM_ROWS] = '{
        '{8'd2, 48'h020000000001, 48'h0200000000a1, 16'h0800, 16'd32, 64'h11, 8'd0},
        '{8'd2, 48'h020000000002, 48'h0200000000a2, 16'h86dd, 16'd1, 64'h22, 8'd0},
        '{8'd4, 48'h020000000003, 48'h0200000000a3, 16'h0806, 16'd96, 64'h33, 8'd3},
        '{8'd5, 48'h020000000004, 48'h0200000000a4, 16'h0800, 16'd100, 64'h44, GAP_RAND},
        '{8'd3, 48'h020000000005, 48'h0200000000a5, 16'h88f7, 16'd60, 64'h55, 8'd0},
        '{8'd9, 48'h020000000006, 48'h0200000000a6, 16'h0800, 16'd250, 64'h66, GAP_RAND},
        '{8'd2, 48'h020000000007, 48'h0200000000a7, 16'h8100, 16'd17, 64'h77, 8'd1},
        '{8'd6, 48'h020000000008, 48'h0200000000a8, 16'h0800, 16'd160, 64'h88, 8'd0}
    };

    logic                           clk;
    logic                           rst;
    logic                           noc_in_val;
    logic [`NOC_DATA_WIDTH-1:0]     noc_in_data;
    logic                           mac_val;
    mac_beat_e                      mac_kind;
    logic [`MAC_INTERFACE_W-1:0]    mac_data;
    logic                           mac_last;
    logic [`MAC_PADBYTES_W-1:0]     mac_padbytes;
    logic [15:0]                    frames_sent;

    exp_beat_t  exp_q [$];
    int         gaps [NUM_ROWS];
    int         row_errs [NUM_ROWS];
    int         cycle = 0;
    int         limit = 0;
    int         errors = 0;
    int         frames_expected = 0;
    int         tests_passed = 0;
    int         tests_failed = 0;

    eth_tx_noc_in dut0 (
         .clk           (clk)
        ,.rst           (rst)
        ,.noc_in_val    (noc_in_val)
        ,.noc_in_data   (noc_in_data)
        ,.mac_val       (mac_val)
        ,.mac_kind      (mac_kind)
        ,.mac_data      (mac_data)
        ,.mac_last      (mac_last)
        ,.mac_padbytes  (mac_padbytes)
        ,.frames_sent   (frames_sent)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (limit != 0 && cycle >= limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic logic [`NOC_DATA_WIDTH-1:0] random_flit();
        logic [`NOC_DATA_WIDTH-1:0] f;
        for (int i = 0; i < `NOC_DATA_WIDTH / 32; i++) begin
            f[i*32 +: 32] = $urandom;
        end
        return f;
    endfunction

    // Bytes that land in the final flit leave the rest of the beat unused.
    function automatic logic [`MAC_PADBYTES_W-1:0] expected_pad(input int size,
                                                                input int n_data);
        int used;
        used = size - `MAC_INTERFACE_BYTES * (n_data - 1);
        if (used == `MAC_INTERFACE_BYTES) begin
            return '0;
        end
        return `MAC_PADBYTES_W'(`MAC_INTERFACE_BYTES - used);
    endfunction

    task automatic note_error(input int row);
        errors++;
        if (row >= 0) begin
            row_errs[row]++;
        end
    endtask

    task automatic check_field(input string name, input logic [255:0] got,
                               input logic [255:0] exp, input int row);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            note_error(row);
        end
    endtask

    task automatic report_test(input string name, input int errs);
        if (errs == 0) begin
            tests_passed++;
            $display("Test %s: pass", name);
        end
        else begin
            tests_failed++;
            $display("Test %s: FAIL with %0d errors", name, errs);
        end
    endtask

    task automatic check_outputs();
        exp_beat_t e;
        if (exp_q.size() != 0 && exp_q[0].due == cycle) begin
            e = exp_q.pop_front();
            if (!mac_val) begin
                $display("Beat of message %0d missing at cycle %0d", e.row, cycle);
                note_error(e.row);
            end
            else begin
                check_field("mac_kind", 256'(mac_kind), 256'(e.kind), e.row);
                check_field("mac_data", mac_data, e.data, e.row);
                check_field("mac_last", 256'(mac_last), 256'(e.last), e.row);
                check_field("mac_padbytes", 256'(mac_padbytes), 256'(e.pad), e.row);
            end
            if (e.last) begin
                frames_expected++;
                check_field("frames_sent", 256'(frames_sent), 256'(frames_expected), e.row);
                report_test($sformatf("message %0d (len %0d, payload %0d)", e.row,
                            rows[e.row].msg_len, rows[e.row].payload_size), row_errs[e.row]);
            end
        end
        else begin
            if (mac_val) begin
                $display("Beat appeared at cycle %0d with no flit to cause it", cycle);
                note_error(-1);
            end
            check_field("mac_last", 256'(mac_last), 256'(0), -1);
        end
    endtask

    task automatic step_cycle();
        @(negedge clk);
        check_outputs();
    endtask

    task automatic send_message(input int r);
        noc_hdr_flit        hdr;
        eth_tx_meta_flit    meta;
        exp_beat_t          e;
        int                 n_data;
        n_data = int'(rows[r].msg_len) - 1;
        repeat (gaps[r]) begin
            step_cycle();
            noc_in_val  = 1'b0;
            noc_in_data = '0;
        end
        hdr = '0;
        hdr.core.msg_len = rows[r].msg_len;
        hdr.core.dst     = 16'(r);
        hdr.core.src     = 16'h00a5;
        step_cycle();
        noc_in_val  = 1'b1;
        noc_in_data = hdr;
        meta = '0;
        meta.eth_dst      = rows[r].eth_dst;
        meta.eth_src      = rows[r].eth_src;
        meta.eth_type     = rows[r].eth_type;
        meta.payload_size = rows[r].payload_size;
        meta.timestamp    = rows[r].timestamp;
        step_cycle();
        noc_in_data = meta;
        e.kind = BEAT_HDR;
        e.data = '0;
        e.data[47:0]    = rows[r].eth_dst;
        e.data[95:48]   = rows[r].eth_src;
        e.data[111:96]  = rows[r].eth_type;
        e.data[127:112] = rows[r].payload_size;
        e.data[191:128] = rows[r].timestamp;
        e.last = 1'b0;
        e.pad  = '0;
        e.due  = cycle + 1;
        e.row  = r;
        exp_q.push_back(e);
        for (int i = 0; i < n_data; i++) begin
            step_cycle();
            noc_in_data = random_flit();
            e.kind = BEAT_DATA;
            e.data = noc_in_data;
            e.last = (i == n_data - 1);
            e.pad  = e.last ? expected_pad(int'(rows[r].payload_size), n_data) : '0;
            e.due  = cycle + 1;
            exp_q.push_back(e);
        end
    endtask

    initial begin
        int sum;
        void'($urandom(32'h5446));
        rst         = 1'b1;
        noc_in_val  = 1'b0;
        noc_in_data = '0;
        sum = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            gaps[r] = (rows[r].gap == GAP_RAND) ? int'($urandom % 4) + 1 : int'(rows[r].gap);
            row_errs[r] = 0;
            sum += int'(rows[r].msg_len) + 1 + gaps[r];
        end
        limit = 2 * sum + 50;

        repeat (3) @(negedge clk);
        check_field("mac_val", 256'(mac_val), 256'(0), -1);
        check_field("mac_last", 256'(mac_last), 256'(0), -1);
        check_field("frames_sent", 256'(frames_sent), 256'(0), -1);
        report_test("reset", errors);
        rst = 1'b0;

        for (int r = 0; r < NUM_ROWS; r++) begin
            send_message(r);
        end
        step_cycle();
        noc_in_val  = 1'b0;
        noc_in_data = '0;
        while (exp_q.size() != 0) begin
            step_cycle();
        end
        repeat (2) step_cycle();   // Idle input must stay quiet at the output.

        $display("Tests: %0d passed, %0d failed, %0d errors, %0d frames sent",
                 tests_passed, tests_failed, errors, frames_sent);
        if (errors == 0 && tests_failed == 0 && frames_sent == 16'(NUM_ROWS)) begin
            $display("All checks passed");
        end
        else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/eth_tx_noc_in.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "eth_tx_consts.svh"

module eth_tx_noc_in (
     input  logic                           clk
    ,input  logic                           rst

    ,input  logic                           noc_in_val
    ,input  logic   [`NOC_DATA_WIDTH-1:0]   noc_in_data

    ,output logic                           mac_val
    ,output eth_frame_pkg::mac_beat_e       mac_kind
    ,output logic   [`MAC_INTERFACE_W-1:0]  mac_data
    ,output logic                           mac_last
    ,output logic   [`MAC_PADBYTES_W-1:0]   mac_padbytes

    ,output logic   [15:0]                  frames_sent
);

    import noc_msg_pkg::*;
    import eth_frame_pkg::*;

    logic                           store_hdr_flit;
    logic                           store_meta_flit;
    logic                           init_num_flits;
    logic                           decr_num_flits;
    logic                           last_flit;
    logic                           hdr_val;
    logic                           data_val;

    eth_hdr                         hdr_fields;
    logic   [`MTU_SIZE_W-1:0]       payload_len;
    logic   [MSG_TIMESTAMP_W-1:0]   timestamp;
    logic   [`MAC_INTERFACE_W-1:0]  data;
    logic                           data_last;
    logic   [`MAC_PADBYTES_W-1:0]   data_padbytes;

    eth_tx_noc_in_ctrl ctrl0 (
         .clk               (clk)
        ,.rst               (rst)
        ,.noc_in_val        (noc_in_val)
        ,.last_flit         (last_flit)
        ,.store_hdr_flit    (store_hdr_flit)
        ,.store_meta_flit   (store_meta_flit)
        ,.init_num_flits    (init_num_flits)
        ,.decr_num_flits    (decr_num_flits)
        ,.hdr_val           (hdr_val)
        ,.data_val          (data_val)
    );

    eth_tx_noc_in_datap datap0 (
         .clk               (clk)
        ,.rst               (rst)
        ,.noc_in_data       (noc_in_data)
        ,.store_hdr_flit    (store_hdr_flit)
        ,.store_meta_flit   (store_meta_flit)
        ,.init_num_flits    (init_num_flits)
        ,.decr_num_flits    (decr_num_flits)
        ,.eth_hdr_out       (hdr_fields)
        ,.payload_len       (payload_len)
        ,.timestamp         (timestamp)
        ,.data              (data)
        ,.data_last         (data_last)
        ,.data_padbytes     (data_padbytes)
        ,.last_flit         (last_flit)
    );

    eth_tx_frame_fmt fmt0 (
         .clk               (clk)
        ,.rst               (rst)
        ,.hdr_val           (hdr_val)
        ,.data_val          (data_val)
        ,.eth_hdr_in        (hdr_fields)
        ,.payload_len       (payload_len)
        ,.timestamp         (timestamp)
        ,.data              (data)
        ,.data_last         (data_last)
        ,.data_padbytes     (data_padbytes)
        ,.mac_val           (mac_val)
        ,.mac_kind          (mac_kind)
        ,.mac_data          (mac_data)
        ,.mac_last          (mac_last)
        ,.mac_padbytes      (mac_padbytes)
        ,.frames_sent       (frames_sent)
    );

endmodule

`default_nettype wire

// ==== hw/eth_tx_frame_fmt.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "eth_tx_consts.svh"

module eth_tx_frame_fmt (
     input  logic                                       clk
    ,input  logic                                       rst

    ,input  logic                                       hdr_val
    ,input  logic                                       data_val

    ,input  eth_frame_pkg::eth_hdr                      eth_hdr_in
    ,input  logic   [`MTU_SIZE_W-1:0]                   payload_len
    ,input  logic   [noc_msg_pkg::MSG_TIMESTAMP_W-1:0]  timestamp

    ,input  logic   [`MAC_INTERFACE_W-1:0]              data
    ,input  logic                                       data_last
    ,input  logic   [`MAC_PADBYTES_W-1:0]               data_padbytes

    ,output logic                                       mac_val
    ,output eth_frame_pkg::mac_beat_e                   mac_kind
    ,output logic   [`MAC_INTERFACE_W-1:0]              mac_data
    ,output logic                                       mac_last
    ,output logic   [`MAC_PADBYTES_W-1:0]               mac_padbytes

    ,output logic   [15:0]                              frames_sent
);

    import noc_msg_pkg::*;
    import eth_frame_pkg::*;

    localparam int HDR_USED_W = 2 * `ETH_ADDR_W + `ETH_TYPE_W + `MTU_SIZE_W
                              + MSG_TIMESTAMP_W;

    logic   [`MAC_INTERFACE_W-1:0]  hdr_beat;
    logic                           frame_done;
    logic                           in_frame;

    // Destination in the lowest bits and zero fill at the top.
    assign hdr_beat = {
        {(`MAC_INTERFACE_W - HDR_USED_W){1'b0}},
        timestamp,
        payload_len,
        eth_hdr_in.eth_type,
        eth_hdr_in.src,
        eth_hdr_in.dst
    };

    assign frame_done = data_val && data_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            mac_val     <= 1'b0;
            mac_last    <= 1'b0;
            frames_sent <= '0;
            in_frame    <= 1'b0;
        end
        else begin
            mac_val  <= hdr_val || data_val;
            mac_last <= frame_done;
            if (frame_done) begin
                frames_sent <= frames_sent + 16'd1;   // Wraps.
                in_frame    <= 1'b0;
            end
            else if (hdr_val) begin
                in_frame <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_val) begin
            mac_kind     <= BEAT_HDR;
            mac_data     <= hdr_beat;
            mac_padbytes <= '0;
        end
        else if (data_val) begin
            mac_kind     <= BEAT_DATA;
            mac_data     <= data;
            mac_padbytes <= data_padbytes;
        end
    end

    a_data_in_frame: assert property (
        @(posedge clk) disable iff (rst)
        data_val |-> in_frame
    ) else $error("data beat outside of a frame");

    a_hdr_opens_frame: assert property (
        @(posedge clk) disable iff (rst)
        hdr_val |-> !in_frame
    ) else $error("header beat inside an open frame");

endmodule

`default_nettype wire

// ==== hw/eth_tx_noc_in_datap.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "eth_tx_consts.svh"

module eth_tx_noc_in_datap (
     input  logic                                       clk
    ,input  logic                                       rst

    ,input  logic   [`NOC_DATA_WIDTH-1:0]               noc_in_data

    ,input  logic                                       store_hdr_flit
    ,input  logic                                       store_meta_flit
    ,input  logic                                       init_num_flits
    ,input  logic                                       decr_num_flits

    ,output eth_frame_pkg::eth_hdr                      eth_hdr_out
    ,output logic   [`MTU_SIZE_W-1:0]                   payload_len
    ,output logic   [noc_msg_pkg::MSG_TIMESTAMP_W-1:0]  timestamp

    ,output logic   [`MAC_INTERFACE_W-1:0]              data
    ,output logic                                       data_last
    ,output logic   [`MAC_PADBYTES_W-1:0]               data_padbytes

    ,output logic                                       last_flit
);

    import noc_msg_pkg::*;

    noc_hdr_flit        hdr_flit_reg;
    noc_hdr_flit        hdr_flit_next;

    eth_tx_meta_flit    meta_flit_reg;
    eth_tx_meta_flit    meta_flit_next;

    logic   [`MSG_LENGTH_WIDTH-1:0]         flits_remaining_reg;
    logic   [`MSG_LENGTH_WIDTH-1:0]         flits_remaining_next;

    logic   [`MAC_INTERFACE_BYTES_W-1:0]    size_rem;
    logic   [`MAC_PADBYTES_W-1:0]           padbytes_calc;

    assign hdr_flit_next  = store_hdr_flit  ? noc_in_data : hdr_flit_reg;
    assign meta_flit_next = store_meta_flit ? noc_in_data : meta_flit_reg;

    always_ff @(posedge clk) begin
        hdr_flit_reg  <= hdr_flit_next;
        meta_flit_reg <= meta_flit_next;
    end

    always_comb begin
        if (init_num_flits) begin
            flits_remaining_next = hdr_flit_next.core.msg_len;
        end
        else if (decr_num_flits) begin
            flits_remaining_next = flits_remaining_reg - 1'b1;
        end
        else begin
            flits_remaining_next = flits_remaining_reg;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flits_remaining_reg <= '0;
        end
        else begin
            flits_remaining_reg <= flits_remaining_next;
        end
    end

    // Header beat is built in the metadata cycle, so use the incoming flit.
    assign eth_hdr_out.dst      = meta_flit_next.eth_dst;
    assign eth_hdr_out.src      = meta_flit_next.eth_src;
    assign eth_hdr_out.eth_type = meta_flit_next.eth_type;
    assign payload_len          = meta_flit_next.payload_size;
    assign timestamp            = meta_flit_next.timestamp;

    assign last_flit = flits_remaining_reg == `MSG_LENGTH_WIDTH'(1);

    // Unused bytes in the final beat.
    assign size_rem      = meta_flit_reg.payload_size[`MAC_INTERFACE_BYTES_W-1:0];
    assign padbytes_calc = (size_rem == '0)
                         ? '0
                         : `MAC_PADBYTES_W'(`MAC_INTERFACE_BYTES - size_rem);

    assign data          = noc_in_data;
    assign data_last     = last_flit;
    assign data_padbytes = data_last ? padbytes_calc : '0;

    a_no_underflow: assert property (
        @(posedge clk) disable iff (rst)
        (decr_num_flits && !init_num_flits) |-> (flits_remaining_reg != '0)
    ) else $error("flit counter decremented below zero");

endmodule

`default_nettype wire

// ==== hw/eth_tx_noc_in_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module eth_tx_noc_in_ctrl (
     input  logic   clk
    ,input  logic   rst

    ,input  logic   noc_in_val
    ,input  logic   last_flit

    ,output logic   store_hdr_flit
    ,output logic   store_meta_flit
    ,output logic   init_num_flits
    ,output logic   decr_num_flits

    ,output logic   hdr_val
    ,output logic   data_val
);

    import noc_msg_pkg::*;

    noc_in_state_e  state_reg;
    noc_in_state_e  state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= IDLE;
        end
        else begin
            state_reg <= state_next;
        end
    end

    always_comb begin
        store_hdr_flit  = 1'b0;
        store_meta_flit = 1'b0;
        init_num_flits  = 1'b0;
        decr_num_flits  = 1'b0;
        hdr_val         = 1'b0;
        data_val        = 1'b0;
        state_next      = state_reg;

        case (state_reg)
            IDLE: begin
                if (noc_in_val) begin
                    store_hdr_flit = 1'b1;
                    init_num_flits = 1'b1;   // Length comes with the header.
                    state_next     = META;
                end
            end
            META: begin
                if (noc_in_val) begin
                    store_meta_flit = 1'b1;
                    decr_num_flits  = 1'b1;
                    hdr_val         = 1'b1;
                    state_next      = DATA;
                end
            end
            DATA: begin
                if (noc_in_val) begin
                    decr_num_flits = 1'b1;
                    data_val       = 1'b1;
                    if (last_flit) begin
                        state_next = IDLE;   // Next flit opens a new message.
                    end
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    a_store_exclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(store_hdr_flit && store_meta_flit)
    ) else $error("header and metadata flits stored in the same cycle");

endmodule

`default_nettype wire

// ==== hw/eth_frame_pkg.sv ====
`default_nettype none

`include "eth_tx_consts.svh"

package eth_frame_pkg;

    // Wire order of a 14-byte Ethernet header.
    typedef struct packed {
        logic [`ETH_ADDR_W-1:0] dst;
        logic [`ETH_ADDR_W-1:0] src;
        logic [`ETH_TYPE_W-1:0] eth_type;
    } eth_hdr;

    localparam int ETH_HDR_W = $bits(eth_hdr);

    // A header beat opens every frame, data beats follow.
    typedef enum logic {
        BEAT_HDR  = 1'b0,
        BEAT_DATA = 1'b1
    } mac_beat_e;

endpackage

`default_nettype wire

// ==== hw/noc_msg_pkg.sv ====
`default_nettype none

`include "eth_tx_consts.svh"

package noc_msg_pkg;

    localparam int MSG_TIMESTAMP_W = 64;

    localparam int NOC_NODE_W      = 16;
    localparam int NOC_HDR_CORE_W  = `MSG_LENGTH_WIDTH + 2 * NOC_NODE_W;

    typedef struct packed {
        logic [`MSG_LENGTH_WIDTH-1:0]   msg_len;   // Flits after the header.
        logic [NOC_NODE_W-1:0]          dst;
        logic [NOC_NODE_W-1:0]          src;
    } noc_hdr_core;

    typedef struct packed {
        noc_hdr_core                                core;
        logic [`NOC_DATA_WIDTH-NOC_HDR_CORE_W-1:0]  fill;
    } noc_hdr_flit;

    localparam int META_USED_W = 2 * `ETH_ADDR_W + `ETH_TYPE_W + `MTU_SIZE_W
                               + MSG_TIMESTAMP_W;

    typedef struct packed {
        logic [`ETH_ADDR_W-1:0]                 eth_dst;
        logic [`ETH_ADDR_W-1:0]                 eth_src;
        logic [`ETH_TYPE_W-1:0]                 eth_type;
        logic [`MTU_SIZE_W-1:0]                 payload_size;  // Bytes.
        logic [MSG_TIMESTAMP_W-1:0]             timestamp;
        logic [`NOC_DATA_WIDTH-META_USED_W-1:0] fill;
    } eth_tx_meta_flit;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        META = 2'd1,
        DATA = 2'd2
    } noc_in_state_e;

endpackage

`default_nettype wire

// ==== hw/eth_tx_consts.svh ====
`ifndef ETH_TX_CONSTS_SVH
`define ETH_TX_CONSTS_SVH

// NoC side.
`define NOC_DATA_WIDTH          256
`define MSG_LENGTH_WIDTH        8

// MAC side.
`define MAC_INTERFACE_W         256
`define MAC_INTERFACE_BYTES     32
`define MAC_INTERFACE_BYTES_W   5
`define MAC_PADBYTES_W          5

// Payload size in bytes, up to a jumbo frame.
`define MTU_SIZE_W              16

// Ethernet header fields.
`define ETH_ADDR_W              48
`define ETH_TYPE_W              16

`endif
